//--- dv/tb_periph_subsystem.sv
// Directed testbench with one bus access at a time and a rule model of the PLIC
`timescale 1ns/1ps
`include "periph_params.svh"

module tb_periph_subsystem;

    localparam int NUM_SRC        = `PERIPH_NUM_SRC;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                           clk_i;
    logic                           rst_n_i;
    periph_bus_pkg::reg_req_t       req_i;
    logic [`PERIPH_NUM_EXT-1:0]     ext_irq_i;
    periph_bus_pkg::reg_rsp_t       rsp_o;
    logic [`PERIPH_NUM_TGT-1:0]     irq_o;

    logic [31:0] lcg_state = 32'h116d;
    int          cycle_count = 0;

    // Reference state of the PLIC
    logic [`PERIPH_PRIO_W-1:0]  prio_m [NUM_SRC];
    logic [NUM_SRC-1:0]         en_m [`PERIPH_NUM_TGT];
    logic [`PERIPH_PRIO_W-1:0]  th_m [`PERIPH_NUM_TGT];
    logic [NUM_SRC-1:0]         level_m;
    logic [NUM_SRC-1:0]         insvc_m;

    periph_subsystem dut (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .ext_irq_i (ext_irq_i),
        .rsp_o     (rsp_o),
        .irq_o     (irq_o)
    );

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not complete", cycle_count);
            stop_on_failure();
        end
    end

    // --------------------
    // Helpers
    // --------------------
    task automatic stop_on_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test, what, exp, act);
            stop_on_failure();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [3:0] win, input logic [11:0] off);
        return {16'h0, win, off};
    endfunction

    // The response has to appear exactly one cycle after the request
    task automatic bus_access(input string test, input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output periph_bus_pkg::reg_rsp_t rsp);
        @(posedge clk_i);
        req_i.valid <= 1'b1;
        req_i.write <= write;
        req_i.addr  <= addr;
        req_i.wdata <= wdata;
        @(negedge clk_i);
        assert (rsp_o.valid === 1'b0) else begin
            $display("In %s the response came in the request cycle", test);
            stop_on_failure();
        end
        @(posedge clk_i);
        req_i.valid <= 1'b0;
        @(negedge clk_i);
        assert (rsp_o.valid === 1'b1) else begin
            $display("In %s no response came one cycle after the request", test);
            stop_on_failure();
        end
        rsp = rsp_o;
    endtask

    task automatic bus_write(input string test, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic exp_err);
        periph_bus_pkg::reg_rsp_t rsp;
        bus_access(test, 1'b1, addr, wdata, rsp);
        check_value(test, "write err", 32'(exp_err), 32'(rsp.err));
        check_value(test, "write data", 32'h0, rsp.rdata);
    endtask

    task automatic bus_read(input string test, input logic [31:0] addr,
                            input logic exp_err, output logic [31:0] rdata);
        periph_bus_pkg::reg_rsp_t rsp;
        bus_access(test, 1'b0, addr, 32'h0, rsp);
        check_value(test, "read err", 32'(exp_err), 32'(rsp.err));
        rdata = rsp.rdata;
    endtask

    // Highest priority above the threshold wins and the lowest id breaks a tie
    function automatic int best_id(input int t);
        int id;
        id = 0;
        for (int s = NUM_SRC - 1; s > 0; s--) begin
            if (level_m[s] && !insvc_m[s] && en_m[t][s] && prio_m[s] > th_m[t]
                && (id == 0 || prio_m[s] >= prio_m[id])) begin
                id = s;
            end
        end
        return id;
    endfunction

    function automatic logic [31:0] plic_addr(input int off);
        return reg_addr(periph_bus_pkg::WIN_PLIC, 12'(off));
    endfunction

    function automatic int claim_off(input int t);
        return periph_irq_pkg::PLIC_CLAIM_BASE + periph_irq_pkg::PLIC_TGT_STRIDE * t;
    endfunction

    task automatic plic_claim(input string test, input int t);
        logic [31:0] rdata;
        int          exp_id;
        exp_id = best_id(t);
        bus_read(test, plic_addr(claim_off(t)), 1'b0, rdata);
        check_value(test, "claim id", 32'(exp_id), rdata);
        if (exp_id != 0) begin
            insvc_m[exp_id] = 1'b1;
        end
    endtask

    task automatic plic_complete(input string test, input int t, input int id);
        bus_write(test, plic_addr(claim_off(t)), 32'(id), 1'b0);
        insvc_m[id] = 1'b0;
    endtask

    task automatic check_irq(input string test);
        logic [`PERIPH_NUM_TGT-1:0] exp;
        @(negedge clk_i);
        for (int t = 0; t < `PERIPH_NUM_TGT; t++) begin
            exp[t] = (best_id(t) != 0);
        end
        check_value(test, "irq_o", 32'(exp), 32'(irq_o));
    endtask

    function automatic logic [31:0] timer_addr(input int k, input int off);
        return reg_addr(periph_bus_pkg::WIN_TIMER, 12'(periph_irq_pkg::TIMER_STRIDE * k + off));
    endfunction

    // --------------------
    // Tests
    // --------------------
    task automatic test_error_windows();
        logic [3:0]  wins [5];
        logic [31:0] rdata;
        wins = '{periph_bus_pkg::WIN_UART, periph_bus_pkg::WIN_SPI, periph_bus_pkg::WIN_ETH,
                 4'd7, 4'd15};
        foreach (wins[i]) begin
            bus_write("error_windows", reg_addr(wins[i], 12'(lcg_next())), lcg_next(), 1'b1);
            bus_read("error_windows", reg_addr(wins[i], 12'(lcg_next())), 1'b1, rdata);
            check_value("error_windows", "read data", `PERIPH_ERR_DATA, rdata);
        end
    endtask

    task automatic test_timer_regs();
        logic [31:0] cmp;
        logic [31:0] cnt;
        logic [31:0] rdata;
        for (int k = 0; k < `PERIPH_NUM_TIMER; k++) begin
            cmp = lcg_next();
            cnt = lcg_next();
            bus_write("timer_regs", timer_addr(k, periph_irq_pkg::TIMER_COMPARE), cmp, 1'b0);
            bus_read("timer_regs", timer_addr(k, periph_irq_pkg::TIMER_COMPARE), 1'b0, rdata);
            check_value("timer_regs", "compare", cmp, rdata);
            bus_read("timer_regs", timer_addr(k, periph_irq_pkg::TIMER_COUNT), 1'b0, rdata);
            check_value("timer_regs", "idle count", 32'h0, rdata);
            bus_write("timer_regs", timer_addr(k, periph_irq_pkg::TIMER_COUNT), cnt, 1'b0);
            bus_read("timer_regs", timer_addr(k, periph_irq_pkg::TIMER_COUNT), 1'b0, rdata);
            check_value("timer_regs", "loaded count", cnt, rdata);
            bus_write("timer_regs", timer_addr(k, periph_irq_pkg::TIMER_COUNT), 32'h0, 1'b0);
        end
    endtask

    // Pending sets C+1 cycles after enable and the wait of C+3 leaves margin
    task automatic test_timer_irq();
        int          c;
        logic [31:0] rdata;
        c = 3 + int'(lcg_next() % 5);
        bus_write("timer_irq", timer_addr(0, periph_irq_pkg::TIMER_COMPARE), 32'(c), 1'b0);
        bus_write("timer_irq", timer_addr(0, periph_irq_pkg::TIMER_CTRL), 32'h1, 1'b0);
        repeat (c + 3) @(posedge clk_i);
        bus_read("timer_irq", timer_addr(0, periph_irq_pkg::TIMER_CTRL), 1'b0, rdata);
        check_value("timer_irq", "ctrl pending", 32'h3, rdata);
        // Disable and clear pending together
        bus_write("timer_irq", timer_addr(0, periph_irq_pkg::TIMER_CTRL), 32'h2, 1'b0);
        bus_read("timer_irq", timer_addr(0, periph_irq_pkg::TIMER_CTRL), 1'b0, rdata);
        check_value("timer_irq", "ctrl cleared", 32'h0, rdata);
    endtask

    task automatic test_plic_ext();
        bus_write("plic_ext", plic_addr(4 * 5), 32'd2, 1'b0);
        prio_m[5] = 3'd2;
        bus_write("plic_ext", plic_addr(4 * 6), 32'd5, 1'b0);
        prio_m[6] = 3'd5;
        bus_write("plic_ext", plic_addr(periph_irq_pkg::PLIC_ENABLE_BASE), 32'h60, 1'b0);
        en_m[0] = 8'h60;
        @(posedge clk_i);
        ext_irq_i <= 2'b11;
        level_m[6:5] = 2'b11;
        check_irq("plic_ext");
        plic_claim("plic_ext", 0);
        plic_claim("plic_ext", 0);
        plic_claim("plic_ext", 0);
        @(posedge clk_i);
        ext_irq_i <= 2'b00;
        level_m[6:5] = 2'b00;
        plic_complete("plic_ext", 0, 6);
        plic_complete("plic_ext", 0, 5);
        check_irq("plic_ext");

        // Threshold at the top priority masks both sources
        bus_write("plic_ext", plic_addr(periph_irq_pkg::PLIC_THRESH_BASE), 32'd5, 1'b0);
        th_m[0] = 3'd5;
        @(posedge clk_i);
        ext_irq_i <= 2'b11;
        level_m[6:5] = 2'b11;
        check_irq("plic_ext");
        bus_write("plic_ext", plic_addr(periph_irq_pkg::PLIC_THRESH_BASE), 32'd4, 1'b0);
        th_m[0] = 3'd4;
        check_irq("plic_ext");
        plic_claim("plic_ext", 0);
        // Source 5 stays below the threshold while 6 is in service
        check_irq("plic_ext");
        bus_write("plic_ext", plic_addr(periph_irq_pkg::PLIC_THRESH_BASE), 32'd0, 1'b0);
        th_m[0] = 3'd0;
        // Source 5 is claimable again after its earlier complete
        check_irq("plic_ext");
        plic_claim("plic_ext", 0);
        @(posedge clk_i);
        ext_irq_i <= 2'b00;
        level_m[6:5] = 2'b00;
        plic_complete("plic_ext", 0, 6);
        plic_complete("plic_ext", 0, 5);
        check_irq("plic_ext");
    endtask

    task automatic test_timer_to_tgt1();
        bus_write("timer_tgt1", plic_addr(4 * `PERIPH_SRC_TIMER0), 32'd4, 1'b0);
        prio_m[`PERIPH_SRC_TIMER0] = 3'd4;
        bus_write("timer_tgt1", plic_addr(periph_irq_pkg::PLIC_ENABLE_BASE + 4), 32'h08, 1'b0);
        en_m[1] = 8'h08;
        bus_write("timer_tgt1", timer_addr(0, periph_irq_pkg::TIMER_COUNT), 32'h0, 1'b0);
        bus_write("timer_tgt1", timer_addr(0, periph_irq_pkg::TIMER_COMPARE), 32'd4, 1'b0);
        bus_write("timer_tgt1", timer_addr(0, periph_irq_pkg::TIMER_CTRL), 32'h1, 1'b0);
        repeat (4 + 3) @(posedge clk_i);
        level_m[`PERIPH_SRC_TIMER0] = 1'b1;
        check_irq("timer_tgt1");
        plic_claim("timer_tgt1", 1);
        bus_write("timer_tgt1", timer_addr(0, periph_irq_pkg::TIMER_CTRL), 32'h2, 1'b0);
        level_m[`PERIPH_SRC_TIMER0] = 1'b0;
        plic_complete("timer_tgt1", 1, `PERIPH_SRC_TIMER0);
        check_irq("timer_tgt1");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        rst_n_i   = 1'b0;
        req_i     = '0;
        ext_irq_i = '0;
        level_m   = '0;
        insvc_m   = '0;
        prio_m    = '{default: '0};
        en_m      = '{default: '0};
        th_m      = '{default: '0};
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_value("reset", "response valid", 32'h0, 32'(rsp_o.valid));
        check_value("reset", "irq_o", 32'h0, 32'(irq_o));

        test_error_windows();
        test_timer_regs();
        test_timer_irq();
        test_plic_ext();
        test_timer_to_tgt1();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- periph_subsystem.f
+incdir+verilog
verilog/periph_bus_pkg.sv
verilog/periph_irq_pkg.sv
verilog/periph_bus_decode.sv
verilog/periph_timer.sv
verilog/periph_plic.sv
verilog/periph_resp_merge.sv
verilog/periph_subsystem.sv
dv/tb_periph_subsystem.sv

//--- verilog/periph_bus_decode.sv
// Combinational window decode from addr[15:12]; upper address bits alias, unmapped codes reach no block
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_bus_decode (
    input  periph_bus_pkg::reg_req_t req_i,
    output periph_bus_pkg::reg_req_t plic_req_o,
    output periph_bus_pkg::reg_req_t timer_req_o,
    output periph_bus_pkg::win_e     win_o
);

    periph_bus_pkg::win_e win;

    // --------------------
    // Window extraction
    // --------------------

    // Cast keeps codes outside the enum so the response stage sees them
    assign win = periph_bus_pkg::win_e'(
        req_i.addr[`PERIPH_WIN_LSB+`PERIPH_WIN_W-1:`PERIPH_WIN_LSB]);

    assign win_o = win;

    // --------------------
    // Request routing
    // --------------------

    // Payload goes to both blocks, only the owner sees valid
    always_comb begin
        plic_req_o       = req_i;
        plic_req_o.valid = req_i.valid && (win == periph_bus_pkg::WIN_PLIC);
    end

    always_comb begin
        timer_req_o       = req_i;
        timer_req_o.valid = req_i.valid && (win == periph_bus_pkg::WIN_TIMER);
    end

    // UART, SPI and Ethernet windows have no block behind them

endmodule

//--- verilog/periph_bus_pkg.sv
// Register bus types; no back-pressure, a response always follows one cycle after a request
`include "periph_params.svh"

package periph_bus_pkg;

    // --------------------
    // Request and response
    // --------------------

    // One access per cycle with valid high
    typedef struct packed {
        logic                        valid;
        logic                        write;
        logic [`PERIPH_ADDR_W-1:0]   addr;
        logic [`PERIPH_DATA_W-1:0]   wdata;
    } reg_req_t;

    // Registered response, err set for absent windows
    typedef struct packed {
        logic                        valid;
        logic [`PERIPH_DATA_W-1:0]   rdata;
        logic                        err;
    } reg_rsp_t;

    // --------------------
    // Address windows
    // --------------------

    // Codes not listed here are unmapped and answered with an error
    typedef enum logic [`PERIPH_WIN_W-1:0] {
        WIN_PLIC  = 4'd0,
        WIN_UART  = 4'd1,
        WIN_SPI   = 4'd2,
        WIN_ETH   = 4'd3,
        WIN_TIMER = 4'd4
    } win_e;

endpackage

//--- verilog/periph_irq_pkg.sv
// PLIC and timer register map as byte offsets inside a window; all registers are 32-bit words
`include "periph_params.svh"

package periph_irq_pkg;

    typedef logic [`PERIPH_PRIO_W-1:0]          prio_t;
    typedef logic [$clog2(`PERIPH_NUM_SRC)-1:0] src_id_t;

    // Offset within one window
    typedef logic [`PERIPH_WIN_LSB-1:0]         off_t;

    // --------------------
    // PLIC map
    // --------------------
    localparam off_t PLIC_PRIO_BASE    = 'h000;
    localparam off_t PLIC_PENDING      = 'h100;
    localparam off_t PLIC_ENABLE_BASE  = 'h200;
    localparam off_t PLIC_THRESH_BASE  = 'h300;
    localparam off_t PLIC_CLAIM_BASE   = 'h304;

    localparam int   PLIC_PRIO_STRIDE   = 4;
    localparam int   PLIC_ENABLE_STRIDE = 4;
    // Threshold and claim pair per target
    localparam int   PLIC_TGT_STRIDE    = 8;

    // --------------------
    // Timer map
    // --------------------
    localparam off_t TIMER_STRIDE      = 'h10;
    localparam off_t TIMER_COUNT       = 'h0;
    localparam off_t TIMER_COMPARE     = 'h4;
    localparam off_t TIMER_CTRL        = 'h8;

    // CTRL bits, pending is write one to clear
    localparam int   TIMER_CTRL_EN     = 0;
    localparam int   TIMER_CTRL_PEND   = 1;

endpackage

//--- verilog/periph_params.svh
// Widths, counts and the address map; source 0 is reserved and the window is addr[15:12] only
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// --------------------
// Bus widths
// --------------------
`define PERIPH_ADDR_W     32
`define PERIPH_DATA_W     32

// Window select field, address bits above 15 are ignored
`define PERIPH_WIN_LSB    12
`define PERIPH_WIN_W      4

// Read data of absent and unmapped windows
`define PERIPH_ERR_DATA   32'hDEADBEEF

// --------------------
// Interrupts
// --------------------
`define PERIPH_NUM_SRC    8
`define PERIPH_NUM_TGT    2
`define PERIPH_PRIO_W     3

// Fixed source indices
`define PERIPH_SRC_TIMER0 3
`define PERIPH_SRC_TIMER1 4
`define PERIPH_SRC_EXT0   5
`define PERIPH_NUM_EXT    2

// Timer block
`define PERIPH_NUM_TIMER  2

`endif

//--- verilog/periph_plic.sv
// Level-only PLIC; in-service state is shared by all targets and source 0 never pends or claims
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_plic (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  periph_bus_pkg::reg_req_t     req_i,
    input  logic [`PERIPH_NUM_SRC-1:0]   src_i,
    output logic [`PERIPH_DATA_W-1:0]    rdata_o,
    output logic [`PERIPH_NUM_TGT-1:0]   irq_o
);

    localparam int NS  = `PERIPH_NUM_SRC;
    localparam int NT  = `PERIPH_NUM_TGT;
    localparam int IDW = $bits(periph_irq_pkg::src_id_t);

    periph_irq_pkg::prio_t   [NS-1:0]   prio_q;
    logic                    [NT-1:0][NS-1:0] ie_q;
    periph_irq_pkg::prio_t   [NT-1:0]   thresh_q;
    logic                    [NS-1:0]   in_service_q;

    logic                    [NS-1:0]   pending;
    periph_irq_pkg::src_id_t [NT-1:0]   best_id;
    periph_irq_pkg::prio_t   [NT-1:0]   best_prio;

    periph_irq_pkg::off_t               off;
    logic                               wr_en;
    logic                               rd_en;

    assign off   = req_i.addr[`PERIPH_WIN_LSB-1:0];
    assign wr_en = req_i.valid && req_i.write;
    assign rd_en = req_i.valid && !req_i.write;

    // --------------------
    // Gateways
    // --------------------
    always_comb begin
        pending    = src_i & ~in_service_q;
        pending[0] = 1'b0;
    end

    // --------------------
    // Arbitration
    // --------------------

    // Strict compare gives the lowest id on a tie and enforces the threshold
    always_comb begin
        for (int t = 0; t < NT; t++) begin
            best_id[t]   = '0;
            best_prio[t] = thresh_q[t];
            for (int s = 1; s < NS; s++) begin
                if (pending[s] && ie_q[t][s] && (prio_q[s] > best_prio[t])) begin
                    best_id[t]   = periph_irq_pkg::src_id_t'(s);
                    best_prio[t] = prio_q[s];
                end
            end
            irq_o[t] = (best_id[t] != '0);
        end
    end

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        for (int s = 0; s < NS; s++) begin
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_PRIO_BASE
                                              + periph_irq_pkg::PLIC_PRIO_STRIDE * s)) begin
                rdata_o[`PERIPH_PRIO_W-1:0] = prio_q[s];
            end
        end
        if (off == periph_irq_pkg::PLIC_PENDING) begin
            rdata_o[NS-1:0] = pending;
        end
        for (int t = 0; t < NT; t++) begin
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_ENABLE_BASE
                                              + periph_irq_pkg::PLIC_ENABLE_STRIDE * t)) begin
                rdata_o[NS-1:0] = ie_q[t];
            end
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_THRESH_BASE
                                              + periph_irq_pkg::PLIC_TGT_STRIDE * t)) begin
                rdata_o[`PERIPH_PRIO_W-1:0] = thresh_q[t];
            end
            // Claim returns the current winner, 0 when nothing qualifies
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_CLAIM_BASE
                                              + periph_irq_pkg::PLIC_TGT_STRIDE * t)) begin
                rdata_o[IDW-1:0] = best_id[t];
            end
        end
    end

    // --------------------
    // Registers, claim and complete
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prio_q       <= '0;
            ie_q         <= '0;
            thresh_q     <= '0;
            in_service_q <= '0;
        end else begin
            if (wr_en) begin
                // Priority of source 0 stays 0
                for (int s = 1; s < NS; s++) begin
                    if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_PRIO_BASE
                                                  + periph_irq_pkg::PLIC_PRIO_STRIDE * s)) begin
                        prio_q[s] <= req_i.wdata[`PERIPH_PRIO_W-1:0];
                    end
                end
                for (int t = 0; t < NT; t++) begin
                    if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_ENABLE_BASE
                                                + periph_irq_pkg::PLIC_ENABLE_STRIDE * t)) begin
                        ie_q[t] <= {req_i.wdata[NS-1:1], 1'b0};
                    end
                    if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_THRESH_BASE
                                                + periph_irq_pkg::PLIC_TGT_STRIDE * t)) begin
                        thresh_q[t] <= req_i.wdata[`PERIPH_PRIO_W-1:0];
                    end
                    // Complete releases the written id
                    if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_CLAIM_BASE
                                                + periph_irq_pkg::PLIC_TGT_STRIDE * t)) begin
                        in_service_q[req_i.wdata[IDW-1:0]] <= 1'b0;
                    end
                end
            end
            if (rd_en) begin
                for (int t = 0; t < NT; t++) begin
                    if (off == periph_irq_pkg::off_t'(periph_irq_pkg::PLIC_CLAIM_BASE
                                                + periph_irq_pkg::PLIC_TGT_STRIDE * t)
                        && best_id[t] != '0) begin
                        in_service_q[best_id[t]] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- verilog/periph_resp_merge.sv
// One-cycle registered response with rdata undefined before the first request
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_resp_merge (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        req_valid_i,
    input  logic                        req_write_i,
    input  periph_bus_pkg::win_e        win_i,
    input  logic [`PERIPH_DATA_W-1:0]   plic_rdata_i,
    input  logic [`PERIPH_DATA_W-1:0]   timer_rdata_i,
    output periph_bus_pkg::reg_rsp_t    rsp_o
);

    logic [`PERIPH_DATA_W-1:0] rdata_d;
    logic                      err_d;
    logic [`PERIPH_DATA_W-1:0] rdata_q;
    logic                      err_q;
    logic                      valid_q;

    // Absent and unmapped windows get the error response
    always_comb begin
        rdata_d = '0;
        err_d   = 1'b0;
        case (win_i)
            periph_bus_pkg::WIN_PLIC:  rdata_d = req_write_i ? '0 : plic_rdata_i;
            periph_bus_pkg::WIN_TIMER: rdata_d = req_write_i ? '0 : timer_rdata_i;
            default: begin
                err_d   = 1'b1;
                rdata_d = req_write_i ? '0 : `PERIPH_ERR_DATA;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= req_valid_i;
            if (req_valid_i) begin
                err_q <= err_d;
            end
        end
    end

    // Read data register
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            rdata_q <= rdata_d;
        end
    end

    assign rsp_o = '{valid: valid_q, rdata: rdata_q, err: err_q};

endmodule

//--- verilog/periph_subsystem.sv
// Peripheral subsystem top; UART, SPI and Ethernet exist only as error windows, sources are level only
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_subsystem (
    input  logic                         clk_i,
    input  logic                         rst_n_i,
    input  periph_bus_pkg::reg_req_t     req_i,
    input  logic [`PERIPH_NUM_EXT-1:0]   ext_irq_i,
    output periph_bus_pkg::reg_rsp_t     rsp_o,
    output logic [`PERIPH_NUM_TGT-1:0]   irq_o
);

    periph_bus_pkg::reg_req_t          plic_req;
    periph_bus_pkg::reg_req_t          timer_req;
    periph_bus_pkg::win_e              win;
    logic [`PERIPH_DATA_W-1:0]         plic_rdata;
    logic [`PERIPH_DATA_W-1:0]         timer_rdata;
    logic [`PERIPH_NUM_TIMER-1:0]      timer_irq;
    logic [`PERIPH_NUM_SRC-1:0]        irq_src;

    // Fixed source map, unused sources and source 0 tied low
    always_comb begin
        irq_src = '0;
        irq_src[`PERIPH_SRC_TIMER0] = timer_irq[0];
        irq_src[`PERIPH_SRC_TIMER1] = timer_irq[1];
        irq_src[`PERIPH_SRC_EXT0 +: `PERIPH_NUM_EXT] = ext_irq_i;
    end

    periph_bus_decode u_decode (
        .req_i       (req_i),
        .plic_req_o  (plic_req),
        .timer_req_o (timer_req),
        .win_o       (win)
    );

    periph_timer u_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (timer_req),
        .rdata_o (timer_rdata),
        .irq_o   (timer_irq)
    );

    periph_plic u_plic (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (plic_req),
        .src_i   (irq_src),
        .rdata_o (plic_rdata),
        .irq_o   (irq_o)
    );

    periph_resp_merge u_resp (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_i.valid),
        .req_write_i   (req_i.write),
        .win_i         (win),
        .plic_rdata_i  (plic_rdata),
        .timer_rdata_i (timer_rdata),
        .rsp_o         (rsp_o)
    );

endmodule

//--- verilog/periph_timer.sv
// Two up-counting compare timers; pending is sticky until written 1 in CTRL, COUNT write wins over counting
`timescale 1ns/1ps
`include "periph_params.svh"

module periph_timer (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  periph_bus_pkg::reg_req_t       req_i,
    output logic [`PERIPH_DATA_W-1:0]      rdata_o,
    output logic [`PERIPH_NUM_TIMER-1:0]   irq_o
);

    localparam int NT = `PERIPH_NUM_TIMER;

    logic [NT-1:0][`PERIPH_DATA_W-1:0] count_q;
    logic [NT-1:0][`PERIPH_DATA_W-1:0] cmp_q;
    logic [NT-1:0]                     en_q;
    logic [NT-1:0]                     pend_q;

    periph_irq_pkg::off_t              off;
    logic                              wr_en;

    assign off   = req_i.addr[`PERIPH_WIN_LSB-1:0];
    assign wr_en = req_i.valid && req_i.write;

    // --------------------
    // Read mux
    // --------------------
    always_comb begin
        rdata_o = '0;
        for (int k = 0; k < NT; k++) begin
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::TIMER_STRIDE * k
                                              + periph_irq_pkg::TIMER_COUNT)) begin
                rdata_o = count_q[k];
            end
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::TIMER_STRIDE * k
                                              + periph_irq_pkg::TIMER_COMPARE)) begin
                rdata_o = cmp_q[k];
            end
            if (off == periph_irq_pkg::off_t'(periph_irq_pkg::TIMER_STRIDE * k
                                              + periph_irq_pkg::TIMER_CTRL)) begin
                rdata_o[periph_irq_pkg::TIMER_CTRL_EN]   = en_q[k];
                rdata_o[periph_irq_pkg::TIMER_CTRL_PEND] = pend_q[k];
            end
        end
    end

    // --------------------
    // Counters and registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            en_q    <= '0;
            pend_q  <= '0;
        end else begin
            for (int k = 0; k < NT; k++) begin
                // Wrap to zero on match and flag the interrupt
                if (en_q[k]) begin
                    if (count_q[k] == cmp_q[k]) begin
                        count_q[k] <= '0;
                        pend_q[k]  <= 1'b1;
                    end else begin
                        count_q[k] <= count_q[k] + 1'b1;
                    end
                end

                if (wr_en && off == periph_irq_pkg::off_t'(periph_irq_pkg::TIMER_STRIDE * k
                                          + periph_irq_pkg::TIMER_COUNT)) begin
                    count_q[k] <= req_i.wdata;
                end
                if (wr_en && off == periph_irq_pkg::off_t'(periph_irq_pkg::TIMER_STRIDE * k
                                          + periph_irq_pkg::TIMER_COMPARE)) begin
                    cmp_q[k] <= req_i.wdata;
                end
                if (wr_en && off == periph_irq_pkg::off_t'(periph_irq_pkg::TIMER_STRIDE * k
                                          + periph_irq_pkg::TIMER_CTRL)) begin
                    en_q[k] <= req_i.wdata[periph_irq_pkg::TIMER_CTRL_EN];
                    // Clear beats a match in the same cycle
                    if (req_i.wdata[periph_irq_pkg::TIMER_CTRL_PEND]) begin
                        pend_q[k] <= 1'b0;
                    end
                end
            end
        end
    end

    // Level interrupt straight from the sticky flag
    assign irq_o = pend_q;

endmodule
